// File: src_streamer_defines.svh
// widths and depths of the source streamer
// include wherever a width or a FIFO depth is needed

`ifndef SRC_STREAMER_DEFINES_SVH
`define SRC_STREAMER_DEFINES_SVH

// byte address
`define SRC_ADDR_W 32

// one stream item
`define SRC_STRM_W 32

// memory bus is one word wider than the stream, for misaligned reads
`define SRC_MEM_W (`SRC_STRM_W + 32)

// length and beat counters
`define SRC_CNT_W 16

`define SRC_ADDR_FIFO_DEPTH 2
`define SRC_OFFS_FIFO_DEPTH 8 // also max loads in flight

`endif

// File: src_streamer_pkg.sv
// types shared by the source streamer modules
// import with a wildcard in the module header

`default_nettype none

`include "src_streamer_defines.svh"

package src_streamer_pkg;

  typedef logic [`SRC_ADDR_W-1:0] addr_t;
  typedef logic [`SRC_STRM_W-1:0] strm_data_t;
  typedef logic [`SRC_MEM_W-1:0]  mem_data_t;
  typedef logic [1:0]             byte_offs_t; // low address bits
  typedef logic [`SRC_CNT_W-1:0]  cnt_t;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    WORKING = 2'd1,
    DONE    = 2'd2
  } streamer_state_t;

  // job setup, held stable by software for the whole job
  typedef struct packed {
    logic  ignore_bias; // no bias beat for this job
    addr_t base_addr;
    cnt_t  tot_len;     // number of stream beats
    cnt_t  d0_len;      // inner loop length
    addr_t d0_stride;
    addr_t d1_stride;
  } pattern_cfg_t;

  typedef struct packed {
    logic ready_start;
    logic done;         // one-cycle pulse at job end
    logic addr_done;
  } streamer_flags_t;

endpackage

`default_nettype wire

// File: stream_fifo.sv
// valid/ready FIFO, circular buffer with a fill count
// payload type set by parameter; no fall-through, pop one cycle after push

`timescale 1ns/10ps
`default_nettype none

module stream_fifo
  import src_streamer_pkg::*;
#(
  parameter type         payload_t = addr_t,
  parameter int unsigned DEPTH     = 2
) (
  input  wire      clk_i,
  input  wire      rst_ni,
  input  wire      clear_i,
  input  wire      push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  wire      pop_ready_i,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH]; // storage, no reset
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push, pop;

  assign empty_o      = (cnt_q == '0);
  assign full_o       = (cnt_q == CNT_W'(DEPTH));
  assign push_ready_o = ~full_o;
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin // drop everything
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push & ~pop)      cnt_q <= cnt_q + 1'b1;
      else if (pop & ~push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: src_addr_gen.sv
// biased two-dimensional byte address generator
// loaded at job start, then emits one address per cycle as a valid/ready stream

`timescale 1ns/10ps
`default_nettype none

module src_addr_gen
  import src_streamer_pkg::*;
(
  input  wire          clk_i,
  input  wire          rst_ni,
  input  wire          clear_i,
  input  wire          enable_i,
  input  wire          run_i,       // job in WORKING
  input  wire          load_i,      // capture cfg_i
  input  pattern_cfg_t cfg_i,
  input  wire          bias_valid_i,
  input  addr_t        bias_data_i,
  output logic         bias_ready_o,
  output logic         addr_valid_o,
  output addr_t        addr_o,
  input  wire          addr_ready_i,
  output logic         addr_done_o
);

  logic  busy_q, bias_wait_q, done_q;
  cnt_t  tot_cnt_q, d0_cnt_q;             // beat index and inner index
  cnt_t  tot_len_q, d0_len_q;
  addr_t d0_stride_q, d1_stride_q;
  addr_t d1_addr_q;                       // biased base of current row
  addr_t d0_offs_q;                       // offset inside the row
  logic  bias_fire, addr_fire, inner_last, tot_last;

  assign bias_ready_o = enable_i & run_i & bias_wait_q;
  assign addr_valid_o = enable_i & run_i & busy_q & ~bias_wait_q; // bias first
  assign addr_o       = d1_addr_q + d0_offs_q;
  assign addr_done_o  = done_q;

  assign bias_fire  = bias_valid_i & bias_ready_o;
  assign addr_fire  = addr_valid_o & addr_ready_i;
  assign inner_last = (d0_cnt_q == d0_len_q - 1'b1);
  assign tot_last   = (tot_cnt_q == tot_len_q - 1'b1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      bias_wait_q <= 1'b0;
      done_q      <= 1'b0;
      tot_cnt_q   <= '0;
      d0_cnt_q    <= '0;
    end else if (clear_i) begin
      busy_q      <= 1'b0;
      bias_wait_q <= 1'b0;
      done_q      <= 1'b0;
      tot_cnt_q   <= '0;
      d0_cnt_q    <= '0;
    end else if (enable_i) begin
      if (load_i) begin
        busy_q      <= (cfg_i.tot_len != '0);
        bias_wait_q <= ~cfg_i.ignore_bias;
        done_q      <= (cfg_i.tot_len == '0); // empty job
        tot_cnt_q   <= '0;
        d0_cnt_q    <= '0;
      end else begin
        if (bias_fire) bias_wait_q <= 1'b0;
        if (addr_fire) begin
          tot_cnt_q <= tot_cnt_q + 1'b1;
          d0_cnt_q  <= inner_last ? '0 : d0_cnt_q + 1'b1;
          if (tot_last) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;                // high the cycle after last accept
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enable_i) begin
      if (load_i) begin
        tot_len_q   <= cfg_i.tot_len;
        d0_len_q    <= cfg_i.d0_len;
        d0_stride_q <= cfg_i.d0_stride;
        d1_stride_q <= cfg_i.d1_stride;
        d1_addr_q   <= cfg_i.base_addr;
        d0_offs_q   <= '0;
      end else if (bias_fire) begin
        d1_addr_q <= d1_addr_q + bias_data_i; // add bias to base
      end else if (addr_fire) begin
        if (inner_last) begin
          d0_offs_q <= '0;
          d1_addr_q <= d1_addr_q + d1_stride_q; // next row
        end else begin
          d0_offs_q <= d0_offs_q + d0_stride_q;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src_realign.sv
// collects returned read words and realigns them to the requested byte offset
// offsets of issued loads wait in a FIFO until their word leaves on the stream

`timescale 1ns/10ps
`default_nettype none

`include "src_streamer_defines.svh"

module src_realign
  import src_streamer_pkg::*;
(
  input  wire        clk_i,
  input  wire        rst_ni,
  input  wire        clear_i,
  input  wire        enable_i,
  input  wire        issue_i,      // load granted this cycle
  input  byte_offs_t issue_offs_i,
  output logic       offs_full_o,
  input  wire        mem_rvalid_i,
  input  mem_data_t  mem_rdata_i,
  output logic       strm_valid_o,
  output strm_data_t strm_data_o,
  input  wire        strm_ready_i
);

  logic       offs_push_ready, offs_valid;
  byte_offs_t offs;
  logic       hold_valid_q;
  mem_data_t  hold_q;                     // word waiting for the output
  mem_data_t  cur_word, shifted;
  logic       take, beat, hold_load;

  stream_fifo #(
    .payload_t ( byte_offs_t          ),
    .DEPTH     ( `SRC_OFFS_FIFO_DEPTH )
  ) i_offs_fifo (
    .clk_i        ( clk_i           ),
    .rst_ni       ( rst_ni          ),
    .clear_i      ( clear_i         ),
    .push_valid_i ( issue_i         ),
    .push_data_i  ( issue_offs_i    ),
    .push_ready_o ( offs_push_ready ),
    .pop_valid_o  ( offs_valid      ),
    .pop_data_o   ( offs            ),
    .pop_ready_i  ( beat            ),
    .empty_o      (                 ),
    .full_o       (                 )
  );

  assign offs_full_o = ~offs_push_ready; // stalls new loads

  assign take = mem_rvalid_i & strm_ready_i; // read return handshake
  // a word without a pending offset is stale, left over from a clear
  assign strm_valid_o = enable_i & offs_valid & (hold_valid_q | mem_rvalid_i);
  assign beat         = strm_valid_o & strm_ready_i;
  assign hold_load    = take & offs_valid & ~(beat & ~hold_valid_q); // not sent straight out

  assign cur_word    = hold_valid_q ? hold_q : mem_rdata_i;
  assign shifted     = cur_word >> {offs, 3'b000};      // shift by whole bytes
  assign strm_data_o = shifted[`SRC_STRM_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (hold_load) begin
      hold_valid_q <= 1'b1;
    end else if (beat) begin
      hold_valid_q <= 1'b0;               // held word accepted
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) hold_q <= mem_rdata_i;
  end

endmodule

`default_nettype wire

// File: src_streamer_ctrl.sv
// job FSM of the source streamer, IDLE -> WORKING -> DONE -> IDLE
// counts output beats and pulses done when the job has drained

`timescale 1ns/10ps
`default_nettype none

module src_streamer_ctrl
  import src_streamer_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             clear_i,
  input  wire             enable_i,
  input  wire             start_i,
  input  cnt_t            tot_len_i,
  input  wire             addr_done_i,
  input  wire             addr_fifo_empty_i,
  input  wire             beat_i,          // output beat transferred
  output streamer_state_t state_o,
  output logic            load_o,
  output logic            run_o,
  output streamer_flags_t flags_o
);

  streamer_state_t state_q, state_d;
  cnt_t            beat_cnt_q;
  logic            finish;

  // all addresses out and all beats delivered
  assign finish = (state_q == DONE) & addr_fifo_empty_i & (beat_cnt_q == tot_len_i);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = WORKING;
      WORKING: if (addr_done_i) state_d = DONE;
      DONE:    if (finish) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end else if (clear_i) begin
      state_q    <= IDLE;
      beat_cnt_q <= '0;
    end else if (enable_i) begin
      state_q <= state_d;
      if (finish)      beat_cnt_q <= '0; // ready for next job
      else if (beat_i) beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  assign state_o             = state_q;
  assign load_o              = enable_i & (state_q == IDLE) & start_i;
  assign run_o               = (state_q == WORKING);
  assign flags_o.ready_start = (state_q == IDLE);
  assign flags_o.done        = enable_i & finish; // one cycle before IDLE
  assign flags_o.addr_done   = addr_done_i;

endmodule

`default_nettype wire

// File: src_streamer.sv
// memory-to-stream source streamer, top level
// loads a biased 2-D pattern over a req/gnt memory port, emits 32-bit stream

`timescale 1ns/10ps
`default_nettype none

`include "src_streamer_defines.svh"

module src_streamer
  import src_streamer_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_ni,
  input  wire             clear_i,
  input  wire             enable_i,
  input  wire             start_i,
  input  pattern_cfg_t    cfg_i,
  output streamer_flags_t flags_o,
  input  wire             bias_valid_i,
  input  addr_t           bias_data_i,
  output logic            bias_ready_o,
  output logic            mem_req_o,
  output addr_t           mem_addr_o,
  input  wire             mem_gnt_i,
  input  wire             mem_rvalid_i,
  input  mem_data_t       mem_rdata_i,
  output logic            mem_rready_o,
  output logic            strm_valid_o,
  output strm_data_t      strm_data_o,
  input  wire             strm_ready_i
);

  streamer_state_t state;
  logic            load, run, addr_done;
  logic            gen_valid, gen_ready;
  addr_t           gen_addr;
  logic            fifo_valid, fifo_empty;
  addr_t           fifo_addr;
  logic            offs_full, issue;

  src_addr_gen i_addr_gen (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .run_i        ( run          ),
    .load_i       ( load         ),
    .cfg_i        ( cfg_i        ),
    .bias_valid_i ( bias_valid_i ),
    .bias_data_i  ( bias_data_i  ),
    .bias_ready_o ( bias_ready_o ),
    .addr_valid_o ( gen_valid    ),
    .addr_o       ( gen_addr     ),
    .addr_ready_i ( gen_ready    ),
    .addr_done_o  ( addr_done    )
  );

  stream_fifo #(
    .payload_t ( addr_t               ),
    .DEPTH     ( `SRC_ADDR_FIFO_DEPTH )
  ) i_addr_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_valid_i ( gen_valid  ),
    .push_data_i  ( gen_addr   ),
    .push_ready_o ( gen_ready  ), // full fifo stalls the generator
    .pop_valid_o  ( fifo_valid ),
    .pop_data_o   ( fifo_addr  ),
    .pop_ready_i  ( issue      ),
    .empty_o      ( fifo_empty ),
    .full_o       (            )
  );

  // no new load while the stream stalls or the offset fifo is full
  assign mem_req_o    = enable_i & fifo_valid & strm_ready_i & ~offs_full & (state != IDLE);
  assign mem_addr_o   = {fifo_addr[`SRC_ADDR_W-1:2], 2'b00}; // word aligned
  assign issue        = mem_req_o & mem_gnt_i;
  assign mem_rready_o = strm_ready_i;

  src_realign i_realign (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .issue_i      ( issue          ),
    .issue_offs_i ( fifo_addr[1:0] ),
    .offs_full_o  ( offs_full      ),
    .mem_rvalid_i ( mem_rvalid_i   ),
    .mem_rdata_i  ( mem_rdata_i    ),
    .strm_valid_o ( strm_valid_o   ),
    .strm_data_o  ( strm_data_o    ),
    .strm_ready_i ( strm_ready_i   )
  );

  src_streamer_ctrl i_ctrl (
    .clk_i, .rst_ni, .clear_i, .enable_i,
    .start_i           ( start_i                     ),
    .tot_len_i         ( cfg_i.tot_len               ),
    .addr_done_i       ( addr_done                   ),
    .addr_fifo_empty_i ( fifo_empty                  ),
    .beat_i            ( strm_valid_o & strm_ready_i ),
    .state_o           ( state                       ),
    .load_o            ( load                        ),
    .run_o             ( run                         ),
    .flags_o           ( flags_o                     )
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// memory model for the streamer testbench
// byte b holds (b*7+3) mod 256, random grant and random in-order read latency

`timescale 1ns/10ps
`default_nettype none

module tb_mem_model
  import src_streamer_pkg::*;
(
  input  wire       clk_i,
  input  int        max_lat_i,     // latency drawn from 1 to this
  input  wire       rand_gnt_i,    // grant on random cycles only
  input  wire       mem_req_i,
  input  addr_t     mem_addr_i,
  output logic      mem_gnt_o,
  output logic      mem_rvalid_o,
  output mem_data_t mem_rdata_o,
  input  wire       mem_rready_i,
  output int        outstanding_o  // granted and not yet taken back
);

  integer seed = 32'h2ef414dd;
  addr_t  addr_q[$];               // pending reads, oldest first
  int     due_q[$];                // cycle from which each word may return
  int     cyc = 0;
  int     last_due = 0;            // keeps returns in order
  int     lat;
  logic   granted, taken;
  addr_t  req_addr;

  // bytes A to A+7, least significant first
  function automatic mem_data_t read_word(input addr_t a);
    mem_data_t w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = 8'((a + i) * 7 + 3);
    end
    return w;
  endfunction

  initial begin
    mem_gnt_o     = 1'b0;
    mem_rvalid_o  = 1'b0;
    mem_rdata_o   = '0;
    outstanding_o = 0;
  end

  always begin
    @(negedge clk_i);              // handshakes are stable here
    granted  = mem_req_i & mem_gnt_o;
    taken    = mem_rvalid_o & mem_rready_i;
    req_addr = mem_addr_i;
    @(posedge clk_i);
    cyc++;
    if (taken) begin
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end
    if (granted) begin
      lat = 1 + (($random(seed) & 32'h7fff_ffff) % max_lat_i);
      if (cyc + lat - 1 > last_due) last_due = cyc + lat - 1;
      addr_q.push_back(req_addr);
      due_q.push_back(last_due);
    end
    #1;
    mem_gnt_o = rand_gnt_i ? (($random(seed) & 1) != 0) : 1'b1;
    if (addr_q.size() > 0 && due_q[0] <= cyc) begin
      mem_rvalid_o = 1'b1;
      mem_rdata_o  = read_word(addr_q[0]); // held until taken
    end else begin
      mem_rvalid_o = 1'b0;
      mem_rdata_o  = '0;
    end
    outstanding_o = addr_q.size();
  end

endmodule

`default_nettype wire

// File: tb_src_streamer.sv
// directed testbench for the source streamer, built from tb.f
// each test runs a job against the pattern memory and checks the realigned stream

`timescale 1ns/10ps
`default_nettype none

`include "src_streamer_defines.svh"

module tb_src_streamer
  import src_streamer_pkg::*;
();

  localparam int TOTAL_BEATS    = 12 + 9 + 15 + 16 + 12 + 12; // all jobs with clear job whole
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS + 200;

  logic            clk, rst_n, clear, enable, start;
  pattern_cfg_t    cfg;
  streamer_flags_t flags;
  logic            bias_valid, bias_ready;
  addr_t           bias_data;
  logic            mem_req, mem_gnt, mem_rvalid, mem_rready;
  addr_t           mem_addr;
  mem_data_t       mem_rdata;
  logic            strm_valid, strm_ready;
  strm_data_t      strm_data;
  int              max_lat, outstanding;
  logic            rand_gnt, backpressure;

  integer     seed = 32'h2ef414dd;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         cycle_cnt = 0;
  strm_data_t got_q[$];            // beats of the current job
  int         done_cnt, bias_cnt, max_outs;

  src_streamer dut (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .clear_i      ( clear      ),
    .enable_i     ( enable     ),
    .start_i      ( start      ),
    .cfg_i        ( cfg        ),
    .flags_o      ( flags      ),
    .bias_valid_i ( bias_valid ),
    .bias_data_i  ( bias_data  ),
    .bias_ready_o ( bias_ready ),
    .mem_req_o    ( mem_req    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_gnt_i    ( mem_gnt    ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  ),
    .mem_rready_o ( mem_rready ),
    .strm_valid_o ( strm_valid ),
    .strm_data_o  ( strm_data  ),
    .strm_ready_i ( strm_ready )
  );

  tb_mem_model i_mem (
    .clk_i         ( clk         ),
    .max_lat_i     ( max_lat     ),
    .rand_gnt_i    ( rand_gnt    ),
    .mem_req_i     ( mem_req     ),
    .mem_addr_i    ( mem_addr    ),
    .mem_gnt_o     ( mem_gnt     ),
    .mem_rvalid_o  ( mem_rvalid  ),
    .mem_rdata_o   ( mem_rdata   ),
    .mem_rready_i  ( mem_rready  ),
    .outstanding_o ( outstanding )
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;        // 100 ns period
  end

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_data(input strm_data_t got, input strm_data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input cnt_t got, input cnt_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [7:0] byte_at(input addr_t b);
    return 8'(b * 7 + 3);          // memory rule
  endfunction

  // address k of the biased 2-D pattern
  function automatic addr_t pattern_addr(input pattern_cfg_t c, input addr_t bias, input int k);
    addr_t base;
    base = c.ignore_bias ? c.base_addr : c.base_addr + bias;
    return base + addr_t'(k % c.d0_len) * c.d0_stride + addr_t'(k / c.d0_len) * c.d1_stride;
  endfunction

  function automatic strm_data_t expected_beat(input pattern_cfg_t c, input addr_t bias,
                                               input int k);
    addr_t      x;
    strm_data_t d;
    x = pattern_addr(c, bias, k);
    for (int i = 0; i < 4; i++) begin
      d[8*i +: 8] = byte_at(x + i);
    end
    return d;
  endfunction

  task automatic start_job(input pattern_cfg_t c, input addr_t bias);
    @(posedge clk);
    #1;
    cfg        = c;
    bias_data  = bias;
    bias_valid = ~c.ignore_bias;   // one bias word offered per job
    start      = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // collects beats until done, or until limit beats if limit > 0
  task automatic collect_beats(input int limit);
    logic finished;
    logic bias_taken;
    finished = 1'b0;
    got_q.delete();
    done_cnt = 0;
    bias_cnt = 0;
    max_outs = 0;
    while (!finished) begin
      @(negedge clk);
      if (strm_valid && strm_ready) got_q.push_back(strm_data);
      if (!strm_ready) begin       // stalled stream blocks loads and returns
        check_flag(mem_req, 1'b0, "mem_req while stream stalled");
        check_flag(mem_rready, 1'b0, "mem_rready while stream stalled");
      end
      bias_taken = bias_valid & bias_ready;
      if (bias_taken) bias_cnt++;
      if (flags.done) begin
        done_cnt++;
        check_flag(flags.addr_done, 1'b1, "addr_done at done");
      end
      if (outstanding > max_outs) max_outs = outstanding;
      finished = flags.done || (limit > 0 && got_q.size() >= limit);
      @(posedge clk);
      #1;
      if (bias_taken) bias_valid = 1'b0;
      strm_ready = backpressure ? (($random(seed) & 3) != 0) : 1'b1;
    end
    strm_ready = 1'b1;
    if (limit == 0) begin
      repeat (3) begin             // done must not pulse again
        @(negedge clk);
        if (flags.done) done_cnt++;
      end
    end
  endtask

  task automatic check_stream(input pattern_cfg_t c, input addr_t bias);
    foreach (got_q[k]) begin
      check_data(got_q[k], expected_beat(c, bias, k), $sformatf("beat %0d", k));
    end
  endtask

  task automatic check_full_job(input pattern_cfg_t c, input addr_t bias);
    check_count(cnt_t'(got_q.size()), c.tot_len, "beat count");
    check_stream(c, bias);
    check_count(cnt_t'(done_cnt), 16'd1, "done pulses");
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    @(negedge clk);
    check_flag(flags.ready_start, 1'b1, "ready_start after reset");
    check_flag(mem_req, 1'b0, "mem_req after reset");
    check_flag(strm_valid, 1'b0, "strm_valid after reset");
    check_flag(bias_ready, 1'b0, "bias_ready after reset");
    check_flag(flags.done, 1'b0, "done after reset");
    check_flag(flags.addr_done, 1'b0, "addr_done after reset");
    report_test("reset state", e0);
  endtask

  task automatic test_aligned();
    pattern_cfg_t c;
    int           e0;
    e0 = errors;
    c = '{ignore_bias: 1'b1, base_addr: 32'h0, tot_len: 16'd12, d0_len: 16'd4,
          d0_stride: 32'd4, d1_stride: 32'd64};
    start_job(c, '0);
    collect_beats(0);
    check_full_job(c, '0);
    report_test("aligned job", e0);
  endtask

  task automatic test_biased();
    pattern_cfg_t c;
    int           e0;
    e0 = errors;
    c = '{ignore_bias: 1'b0, base_addr: 32'h100, tot_len: 16'd9, d0_len: 16'd3,
          d0_stride: 32'd5, d1_stride: 32'h21};
    start_job(c, 32'd6);           // odd offsets from the bias
    collect_beats(0);
    check_full_job(c, 32'd6);
    check_count(cnt_t'(bias_cnt), 16'd1, "bias beats taken");
    report_test("biased job", e0);
  endtask

  task automatic test_backpressure();
    pattern_cfg_t c;
    int           e0;
    e0 = errors;
    c = '{ignore_bias: 1'b1, base_addr: 32'h203, tot_len: 16'd15, d0_len: 16'd5,
          d0_stride: 32'd3, d1_stride: 32'h40};
    max_lat      = 4;
    rand_gnt     = 1'b1;
    backpressure = 1'b1;
    start_job(c, '0);
    collect_beats(0);
    backpressure = 1'b0;
    check_full_job(c, '0);
    report_test("stream back-pressure", e0);
  endtask

  task automatic test_long_latency();
    pattern_cfg_t c;
    int           e0;
    e0 = errors;
    c = '{ignore_bias: 1'b1, base_addr: 32'h401, tot_len: 16'd16, d0_len: 16'd8,
          d0_stride: 32'd4, d1_stride: 32'h100};
    max_lat  = 12;
    rand_gnt = 1'b1;
    start_job(c, '0);
    collect_beats(0);
    check_full_job(c, '0);
    if (max_outs > `SRC_OFFS_FIFO_DEPTH) begin
      errors++;
      $display("CHECK FAILED at %0t ns: outstanding loads reached %0d above the limit of %0d",
               $time, max_outs, `SRC_OFFS_FIFO_DEPTH);
    end
    report_test("long latency", e0);
  endtask

  task automatic test_clear();
    pattern_cfg_t c1, c2;
    int           e0;
    e0 = errors;
    c1 = '{ignore_bias: 1'b1, base_addr: 32'h80, tot_len: 16'd12, d0_len: 16'd4,
           d0_stride: 32'd4, d1_stride: 32'h30};
    c2 = '{ignore_bias: 1'b0, base_addr: 32'h500, tot_len: 16'd12, d0_len: 16'd6,
           d0_stride: 32'd7, d1_stride: 32'h50};
    max_lat  = 6;
    rand_gnt = 1'b1;
    start_job(c1, '0);
    collect_beats(3);              // stop mid job
    check_stream(c1, '0);
    clear      = 1'b1;
    bias_valid = 1'b0;
    @(posedge clk);
    #1;
    clear = 1'b0;
    @(negedge clk);
    check_flag(flags.ready_start, 1'b1, "ready_start after clear");
    while (outstanding != 0) @(negedge clk); // stale reads drain
    max_lat = 3;
    start_job(c2, 32'd3);
    collect_beats(0);
    check_full_job(c2, 32'd3);
    check_count(cnt_t'(bias_cnt), 16'd1, "bias beats taken after clear");
    report_test("clear mid job", e0);
  endtask

  initial begin
    rst_n        = 1'b0;
    clear        = 1'b0;
    enable       = 1'b1;
    start        = 1'b0;
    cfg          = '0;
    bias_valid   = 1'b0;
    bias_data    = '0;
    strm_ready   = 1'b1;
    max_lat      = 3;
    rand_gnt     = 1'b0;
    backpressure = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_aligned();
    test_biased();
    test_backpressure();
    test_long_latency();
    test_clear();
    $display("summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
src_streamer_pkg.sv
stream_fifo.sv
src_addr_gen.sv
src_realign.sv
src_streamer_ctrl.sv
src_streamer.sv
tb_mem_model.sv
tb_src_streamer.sv

// File: Makefile
# Verilator build and run of the source streamer testbench

VERILATOR ?= verilator
TOP       ?= tb_src_streamer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
